//--- rtl/neuronFormatPkg.sv
`default_nettype none

package neuronFormatPkg;

	localparam int FracBits = 8; // Q8.8
	localparam int DataWidth = 16;
	localparam int ItemWidth = 33; // bus word plus the isParam tag
	localparam int IsParamBit = 32;

	typedef logic signed [DataWidth-1:0] fixedT;

	typedef struct packed
	{
		logic [15:0] reserved;
		fixedT activation;
	} featureViewT;

	typedef struct packed
	{
		logic [10:0] reserved;
		logic [4:0] index; // weight number, or NumInputs for the bias
		fixedT value;
	} paramViewT;

	// the same write word reads as a feature or as a parameter, depending on its address
	typedef union packed
	{
		featureViewT featureView;
		paramViewT paramView;
	} wbWordU;

endpackage

`default_nettype wire

//--- rtl/wbMapPkg.sv
`default_nettype none

package wbMapPkg;

	// word addresses sit in adr[3:2] of the byte address
	localparam logic [1:0] AdrFeature = 2'd0; // write only
	localparam logic [1:0] AdrParam = 2'd1; // write only
	localparam logic [1:0] AdrResult = 2'd2; // read only

	// result read word
	localparam int StatusValidBit = 16;
	localparam int StatusCountLsb = 24;
	localparam int StatusCountWidth = 8;

endpackage

`default_nettype wire

//--- rtl/wbFeatureSlave.sv
`default_nettype none

module wbFeatureSlave
	import wbMapPkg::*;
	import neuronFormatPkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic cyc,
	input wire logic stb,
	input wire logic we,
	input wire logic [3:0] adr,
	input wire logic [31:0] datIn,
	output logic [31:0] datOut,
	output logic ack,
	output logic push,
	output logic [ItemWidth-1:0] pushData,
	input wire logic full,
	input wire fixedT result,
	input wire logic resultValid,
	input wire logic [StatusCountWidth-1:0] resultCount,
	output logic resultTaken
);

	logic [1:0] wordAdr;
	logic request;
	logic isDataWrite;
	logic isResultRead;
	logic [31:0] statusWord;

	assign wordAdr = adr[3:2]; // all accesses are whole words
	assign request = cyc && stb && !ack; // the master drops stb after the ack cycle
	assign isDataWrite = we && (wordAdr == AdrFeature || wordAdr == AdrParam);
	assign isResultRead = !we && (wordAdr == AdrResult);

	// a write item is held on the bus until the FIFO has room
	assign push = request && isDataWrite && !full;

	always_comb
	begin
		pushData = ItemWidth'(datIn);
		pushData[IsParamBit] = (wordAdr == AdrParam);
	end

	always_comb
	begin
		statusWord = '0;
		statusWord[DataWidth-1:0] = result;
		statusWord[StatusValidBit] = resultValid;
		statusWord[StatusCountLsb +: StatusCountWidth] = resultCount;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ack <= 1'b0;
			resultTaken <= 1'b0;
		end
		else
		begin
			// reads and dropped writes finish at once, data writes wait for the push
			ack <= request && (!isDataWrite || push);
			resultTaken <= request && isResultRead && resultValid; // only a read that saw valid consumes
		end
	end

	always_ff @(posedge clk)
	begin
		if (request && !we)
			datOut <= isResultRead ? statusWord : '0;
	end

endmodule

`default_nettype wire

//--- rtl/itemFifo.sv
`default_nettype none

module itemFifo
	import neuronFormatPkg::*;
#(
	parameter int FifoDepth = 8
)
(
	input wire logic clk,
	input wire logic reset,
	input wire logic push,
	input wire logic [ItemWidth-1:0] pushData,
	output logic full,
	input wire logic pop,
	output logic [ItemWidth-1:0] popData,
	output logic empty
);

	localparam int PtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
	localparam int CountWidth = $clog2(FifoDepth + 1);

	logic [ItemWidth-1:0] mem [FifoDepth];
	logic [PtrWidth-1:0] wrPtr;
	logic [PtrWidth-1:0] rdPtr;
	logic [CountWidth-1:0] count;
	logic doPush;
	logic doPop;

	// wraps at any depth, not only powers of two
	function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
		return (ptr == PtrWidth'(FifoDepth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign full = (count == CountWidth'(FifoDepth));
	assign empty = (count == '0);
	assign doPush = push && !full;
	assign doPop = pop && !empty;
	assign popData = mem[rdPtr]; // head item

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= nextPtr(wrPtr);
			if (doPop)
				rdPtr <= nextPtr(rdPtr);
			if (doPush && !doPop)
				count <= count + 1'b1;
			else if (doPop && !doPush)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

endmodule

`default_nettype wire

//--- rtl/reluNeuron.sv
`default_nettype none

module reluNeuron
	import neuronFormatPkg::*;
#(
	parameter int NumInputs = 15
)
(
	input wire logic clk,
	input wire logic reset,
	input wire logic empty,
	input wire logic [ItemWidth-1:0] popData,
	output logic pop,
	output fixedT result,
	output logic resultValid,
	output logic [7:0] resultCount,
	input wire logic resultTaken
);

	localparam int CountWidth = (NumInputs > 1) ? $clog2(NumInputs) : 1;

	wbWordU head;
	logic headIsParam;
	logic startsVector;
	logic lastInput;
	logic featurePop;
	logic [CountWidth-1:0] inCount;
	fixedT weights [NumInputs];
	fixedT bias;
	fixedT acc;
	fixedT finalSum;
	logic sumDone; // final sum is registered, the result follows on the next edge
	logic signed [2*DataWidth-1:0] product;
	fixedT scaled;
	fixedT biased;

	assign head = popData[31:0];
	assign headIsParam = popData[IsParamBit];
	assign startsVector = !headIsParam && (inCount == '0);
	assign lastInput = (inCount == CountWidth'(NumInputs - 1));

	// a new vector waits until the held result has been read
	assign pop = !empty && !(startsVector && (resultValid || sumDone));
	assign featurePop = pop && !headIsParam;

	assign product = head.featureView.activation * weights[inCount];
	assign scaled = product[FracBits +: DataWidth]; // bits 23 to 8
	assign biased = finalSum + bias; // wraps at 16 bits like the accumulator

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < NumInputs; i++)
				weights[i] <= '0;
			bias <= '0;
		end
		else if (pop && headIsParam)
		begin
			if (head.paramView.index < 5'(NumInputs))
				weights[head.paramView.index[CountWidth-1:0]] <= head.paramView.value;
			else if (head.paramView.index == 5'(NumInputs))
				bias <= head.paramView.value; // higher indices fall through unused
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			acc <= '0;
			inCount <= '0;
			sumDone <= 1'b0;
		end
		else
		begin
			sumDone <= featurePop && lastInput;
			if (featurePop)
			begin
				acc <= lastInput ? '0 : acc + scaled;
				inCount <= lastInput ? '0 : inCount + 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (featurePop && lastInput)
			finalSum <= acc + scaled;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result <= '0;
			resultValid <= 1'b0;
			resultCount <= '0;
		end
		else if (sumDone)
		begin
			result <= biased[DataWidth-1] ? '0 : biased; // ReLU
			resultValid <= 1'b1;
			resultCount <= resultCount + 8'd1;
		end
		else if (resultTaken)
			resultValid <= 1'b0;
	end

endmodule

`default_nettype wire

//--- rtl/neuronTop.sv
`default_nettype none

module neuronTop
	import neuronFormatPkg::*;
#(
	parameter int NumInputs = 15,
	parameter int FifoDepth = 8
)
(
	input wire logic clk,
	input wire logic reset,
	input wire logic cyc,
	input wire logic stb,
	input wire logic we,
	input wire logic [3:0] adr,
	input wire logic [31:0] datIn,
	output logic [31:0] datOut,
	output logic ack
);

	logic push;
	logic [ItemWidth-1:0] pushData;
	logic full;
	logic pop;
	logic [ItemWidth-1:0] popData;
	logic empty;
	fixedT result;
	logic resultValid;
	logic [7:0] resultCount;
	logic resultTaken;

	wbFeatureSlave i_slave
	(
		.clk(clk),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datIn(datIn),
		.datOut(datOut),
		.ack(ack),
		.push(push),
		.pushData(pushData),
		.full(full),
		.result(result),
		.resultValid(resultValid),
		.resultCount(resultCount),
		.resultTaken(resultTaken)
	);

	// weights and features stay in bus order
	itemFifo #(.FifoDepth(FifoDepth)) i_fifo
	(
		.clk(clk),
		.reset(reset),
		.push(push),
		.pushData(pushData),
		.full(full),
		.pop(pop),
		.popData(popData),
		.empty(empty)
	);

	reluNeuron #(.NumInputs(NumInputs)) i_neuron
	(
		.clk(clk),
		.reset(reset),
		.empty(empty),
		.popData(popData),
		.pop(pop),
		.result(result),
		.resultValid(resultValid),
		.resultCount(resultCount),
		.resultTaken(resultTaken)
	);

endmodule

`default_nettype wire

//--- verif/neuronChecker_checker.sv
`default_nettype none

module neuronChecker_checker
(
	input wire logic clk,
	input wire logic reset,
	input wire logic cyc,
	input wire logic stb,
	input wire logic we,
	input wire logic [3:0] adr,
	input wire logic ack,
	input wire logic push,
	input wire logic full,
	input wire logic resultValid,
	input wire logic resultTaken
);
	timeunit 1ns;
	timeprecision 1ps;

	int failCount = 0;

	ackAfterRequest: assert property (@(posedge clk) disable iff (reset)
		ack |-> $past(cyc && stb))
	else
	begin
		failCount++;
		$error("ack without a preceding cyc and stb");
	end

	ackSingleCycle: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
	else
	begin
		failCount++;
		$error("ack held for more than one cycle");
	end

	noPushWhenFull: assert property (@(posedge clk) disable iff (reset) push |-> !full)
	else
	begin
		failCount++;
		$error("push while the FIFO is full");
	end

	// feature and parameter writes sit on adr[3] == 0 and may only finish after a push
	writeAckNeedsPush: assert property (@(posedge clk) disable iff (reset)
		ack && $past(we && !adr[3]) |-> $past(push))
	else
	begin
		failCount++;
		$error("data write acknowledged without a push");
	end

	validHeld: assert property (@(posedge clk) disable iff (reset)
		resultValid && !resultTaken |=> resultValid)
	else
	begin
		failCount++;
		$error("resultValid dropped before the result was read");
	end

endmodule

bind neuronTop neuronChecker_checker i_checker (.*);

`default_nettype wire

//--- verif/neuronMonitor.sv
`default_nettype none

module neuronMonitor
	import wbMapPkg::*;
#(
	parameter int NumInputs = 15
)
(
	input wire logic clk,
	input wire logic reset,
	input wire logic cyc,
	input wire logic stb,
	input wire logic we,
	input wire logic [3:0] adr,
	input wire logic [31:0] datIn,
	input wire logic [31:0] datOut,
	input wire logic ack,
	output int checkCount,
	output int errorCount
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int VecWidth = NumInputs * 16;

	logic [VecWidth-1:0] modelWeights;
	logic [VecWidth-1:0] vecActs;
	logic [VecWidth-1:0] vecWeights; // weights as they stood when each feature arrived
	logic signed [15:0] modelBias;
	logic signed [15:0] lastResult;
	logic signed [15:0] expectedQ[$];
	logic [7:0] takenCount;
	int inIndex;
	logic reqWe;
	logic [1:0] reqAdr;
	logic [31:0] reqData;

	// each Q8.8 product keeps bits 23 to 8, the sum wraps at 16 bits before bias and ReLU
	function automatic logic signed [15:0] expectedNeuron(input logic [VecWidth-1:0] acts,
		input logic [VecWidth-1:0] wts, input logic signed [15:0] bias);
		logic signed [31:0] product;
		logic signed [15:0] sum;
		sum = '0;
		for (int i = 0; i < NumInputs; i++)
		begin
			product = $signed(acts[i*16 +: 16]) * $signed(wts[i*16 +: 16]);
			sum = sum + product[23:8];
		end
		sum = sum + bias;
		return sum[15] ? 16'sd0 : sum;
	endfunction

	task automatic reportError(input string msg);
		errorCount++;
		$display("** Error at %0d ns: %s", $time, msg);
	endtask

	task automatic finishTransfer();
		logic [4:0] index;
		logic signed [15:0] got;
		logic [7:0] count;
		index = reqData[20:16];
		got = datOut[15:0];
		count = datOut[StatusCountLsb +: 8];
		if (reqWe && reqAdr == AdrFeature)
		begin
			vecActs[inIndex*16 +: 16] = reqData[15:0];
			vecWeights[inIndex*16 +: 16] = modelWeights[inIndex*16 +: 16];
			inIndex++;
			if (inIndex == NumInputs)
			begin
				expectedQ.push_back(expectedNeuron(vecActs, vecWeights, modelBias));
				inIndex = 0;
			end
		end
		else if (reqWe && reqAdr == AdrParam)
		begin
			if (index < NumInputs)
				modelWeights[index*16 +: 16] = reqData[15:0];
			else if (index == NumInputs)
				modelBias = reqData[15:0]; // larger indices leave the model alone
		end
		else if (!reqWe && reqAdr == AdrResult && datOut[StatusValidBit])
		begin
			checkCount++;
			takenCount++;
			if (expectedQ.size() == 0)
				reportError("result valid but no vector was completed");
			else
			begin
				lastResult = expectedQ.pop_front();
				if (got !== lastResult)
					reportError($sformatf("result %h, expected %h", got, lastResult));
			end
			if (count !== takenCount)
				reportError($sformatf("result count %0d, expected %0d", count, takenCount));
		end
		else if (!reqWe && reqAdr == AdrResult && (got !== lastResult || count !== takenCount))
			reportError($sformatf("idle status holds %h count %0d, expected %h count %0d",
				got, count, lastResult, takenCount));
	endtask

	initial
	begin
		checkCount = 0;
		errorCount = 0;
	end

	// a request is latched while it waits and retired on the edge that sees its ack
	always @(posedge clk)
	begin
		if (reset)
		begin
			modelWeights = '0;
			modelBias = '0;
			lastResult = '0;
			takenCount = '0;
			inIndex = 0;
			reqWe = 1'b0;
			reqAdr = '0;
			reqData = '0;
			expectedQ.delete();
		end
		else
		begin
			if (ack)
				finishTransfer();
			if (cyc && stb)
			begin
				reqWe = we;
				reqAdr = adr[3:2];
				reqData = datIn;
			end
		end
	end

endmodule

`default_nettype wire

//--- verif/neuronTb.sv
`default_nettype none

module neuronTb
	import wbMapPkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NumInputs = 15;
	localparam int FifoDepth = 8;
	localparam int NumVectors = 265; // enough to carry the 8-bit result count past 255
	localparam int NumTransfers = NumVectors * (NumInputs + 3) + 100;
	localparam int WatchdogCycles = NumTransfers * 40 + 1000;
	localparam int StallCycles = 20;

	logic clk;
	logic reset;
	logic cyc;
	logic stb;
	logic we;
	logic [3:0] adr;
	logic [31:0] datIn;
	logic [31:0] datOut;
	logic ack;
	int checkCount;
	int errorCount;
	int flowErrors;
	logic [31:0] word;
	logic acked;
	logic [15:0] heldFeature;

	neuronTop #(.NumInputs(NumInputs), .FifoDepth(FifoDepth)) i_dut (.*);
	neuronMonitor #(.NumInputs(NumInputs)) i_monitor (.*);

	always #50 clk = ~clk;

	// one classic cycle driven on falling edges and given up after maxCycles without ack
	task automatic transfer(input logic write, input logic [1:0] wordAdr,
		input logic [31:0] data, input int maxCycles, output logic [31:0] readData,
		output logic done);
		int waited;
		waited = 0;
		done = 1'b0;
		@(negedge clk);
		cyc = 1'b1;
		stb = 1'b1;
		we = write;
		adr = {wordAdr, 2'b00};
		datIn = data;
		while (!done && waited < maxCycles)
		begin
			@(negedge clk);
			done = ack;
			waited++;
		end
		readData = datOut;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic writeWord(input logic [1:0] wordAdr, input logic [31:0] data);
		logic [31:0] readBack;
		logic done;
		transfer(1'b1, wordAdr, data, WatchdogCycles, readBack, done);
	endtask

	task automatic writeParam(input int index, input logic [15:0] value);
		writeWord(AdrParam, {11'd0, 5'(index), value});
	endtask

	task automatic writeFeatures(input int count);
		repeat (count)
			writeWord(AdrFeature, {16'd0, 16'($urandom)});
	endtask

	task automatic collectResult();
		logic [31:0] status;
		logic done;
		status = '0;
		while (!status[StatusValidBit])
			transfer(1'b0, AdrResult, '0, WatchdogCycles, status, done);
	endtask

	initial
	begin
		void'($urandom(69));
		clk = 1'b0;
		reset = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		datIn = '0;
		flowErrors = 0;
		repeat (3) @(negedge clk);
		reset = 1'b0;
		transfer(1'b0, AdrResult, '0, WatchdogCycles, word, acked); // fresh status reads all zero
		for (int i = 0; i < NumInputs; i++)
			writeParam(i, 16'((i + 1) * 64)); // weights 0.25 apart
		writeParam(NumInputs, 16'h0100);
		for (int i = 0; i < NumInputs; i++)
			writeWord(AdrFeature, 32'(16'h0200 - 16'(i * 20)));
		collectResult();
		repeat (NumInputs)
			writeWord(AdrFeature, 32'h0000ff00); // -1.0 everywhere pushes the sum below zero
		collectResult();
		for (int v = 0; v < 20; v++)
		begin
			repeat ($urandom_range(3, 0))
				writeParam($urandom_range(NumInputs, 0), 16'($urandom));
			writeFeatures(NumInputs);
			collectResult();
		end
		repeat (240)
		begin
			writeFeatures(NumInputs);
			collectResult();
		end
		// the unread result stalls the next vector until the FIFO is full
		writeFeatures(NumInputs);
		writeFeatures(FifoDepth);
		heldFeature = 16'($urandom);
		transfer(1'b1, AdrFeature, {16'd0, heldFeature}, StallCycles, word, acked);
		if (acked)
		begin
			flowErrors++;
			$display("A feature write was acknowledged while the FIFO should have been full");
		end
		collectResult();
		if (!acked)
			writeWord(AdrFeature, {16'd0, heldFeature});
		writeFeatures(NumInputs - FifoDepth - 1);
		collectResult();
		writeParam(NumInputs + 1, 16'h7fff); // past the bias slot
		writeParam(31, 16'h8000);
		writeFeatures(NumInputs);
		collectResult();
		repeat (3) @(negedge clk);
		if (checkCount != NumVectors)
			$display("Expected %0d checked results but the monitor saw %0d", NumVectors, checkCount);
		$display("Results checked %0d, data errors %0d, flow errors %0d, assertion failures %0d",
			checkCount, errorCount, flowErrors, i_dut.i_checker.failCount);
		if (errorCount == 0 && flowErrors == 0 && i_dut.i_checker.failCount == 0
			&& checkCount == NumVectors)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	initial
	begin
		#(WatchdogCycles * 100);
		$display("Watchdog expired after %0d cycles, a bus transfer never finished", WatchdogCycles);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
rtl/neuronFormatPkg.sv
rtl/wbMapPkg.sv
rtl/wbFeatureSlave.sv
rtl/itemFifo.sv
rtl/reluNeuron.sv
rtl/neuronTop.sv
verif/neuronChecker_checker.sv
verif/neuronMonitor.sv
verif/neuronTb.sv

//--- Bender.yml
package:
  name: neuron

sources:
  - target: rtl
    files:
      - rtl/neuronFormatPkg.sv
      - rtl/wbMapPkg.sv
      - rtl/wbFeatureSlave.sv
      - rtl/itemFifo.sv
      - rtl/reluNeuron.sv
      - rtl/neuronTop.sv
  - target: test
    files:
      - verif/neuronChecker_checker.sv
      - verif/neuronMonitor.sv
      - verif/neuronTb.sv
